//--- source/wb_pkg.sv
package wb_pkg;

    // issue width of the back end.
    localparam int NUM_LANES_DEF = 2;

    // architectural register file depth.
    localparam int NUM_REGS = 32;

    // architectural register index.
    typedef logic [4:0] reg_addr_t;

    // register and store data word.
    typedef logic [31:0] reg_data_t;

    // instruction address.
    typedef logic [31:0] pc_t;

    // per-cycle lane count, wide enough to hold NUM_LANES_DEF itself.
    typedef logic [$clog2(NUM_LANES_DEF + 1)-1:0] lane_cnt_t;

    // r0 is hardwired to zero and never written.
    localparam reg_addr_t ZERO_REG = '0;

endpackage

//--- source/mem_stage_reg.sv
module mem_stage_reg
    import wb_pkg::*;
#(
    parameter int NUM_LANES = NUM_LANES_DEF
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush_i,
    input  logic                           advance_i,

    input  logic      [NUM_LANES-1:0]      valid_i,
    input  logic      [NUM_LANES-1:0]      excp_i,
    input  logic      [NUM_LANES-1:0]      refetch_i,
    input  logic      [NUM_LANES-1:0]      load_i,
    input  logic      [NUM_LANES-1:0]      store_i,
    input  logic      [NUM_LANES-1:0]      we_i,
    input  reg_addr_t [NUM_LANES-1:0]      waddr_i,
    input  reg_data_t [NUM_LANES-1:0]      wdata_i,
    input  pc_t       [NUM_LANES-1:0]      pc_i,
    input  logic      [NUM_LANES-1:0]      llbit_we_i,
    input  logic      [NUM_LANES-1:0]      llbit_val_i,

    output logic      [NUM_LANES-1:0]      m_valid_o,
    output logic      [NUM_LANES-1:0]      m_excp_o,
    output logic      [NUM_LANES-1:0]      m_refetch_o,
    output logic      [NUM_LANES-1:0]      m_load_o,
    output logic      [NUM_LANES-1:0]      m_store_o,
    output logic      [NUM_LANES-1:0]      m_we_o,
    output reg_addr_t [NUM_LANES-1:0]      m_waddr_o,
    output reg_data_t [NUM_LANES-1:0]      m_wdata_o,
    output pc_t       [NUM_LANES-1:0]      m_pc_o,
    output logic      [NUM_LANES-1:0]      m_llbit_we_o,
    output logic      [NUM_LANES-1:0]      m_llbit_val_o
);

    logic [NUM_LANES-1:0] keep;

    // lanes behind an excepting or refetching lane are squashed.
    always_comb begin
        logic kill;
        kill = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            keep[i] = valid_i[i] & ~kill;
            if (keep[i] && (excp_i[i] || refetch_i[i])) begin
                kill = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            m_valid_o    <= '0;
            m_excp_o     <= '0;
            m_refetch_o  <= '0;
            m_load_o     <= '0;
            m_store_o    <= '0;
            m_we_o       <= '0;
            m_llbit_we_o <= '0;
        end else if (advance_i) begin
            m_valid_o    <= keep;
            m_excp_o     <= excp_i;
            m_refetch_o  <= refetch_i;
            m_load_o     <= load_i;
            m_store_o    <= store_i;
            m_we_o       <= we_i;
            m_llbit_we_o <= llbit_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            m_waddr_o     <= waddr_i;
            m_wdata_o     <= wdata_i;
            m_pc_o        <= pc_i;
            m_llbit_val_o <= llbit_val_i;
        end
    end

    for (genvar i = 0; i < NUM_LANES - 1; i++) begin : g_squash_chk
        for (genvar j = i + 1; j < NUM_LANES; j++) begin : g_later
            assert property (@(posedge clk) disable iff (rst)
                (m_valid_o[i] && (m_excp_o[i] || m_refetch_o[i])) |-> !m_valid_o[j]);
        end
    end

endmodule

//--- source/wb_lane.sv
module wb_lane
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_i,
    input  logic      advance_i,

    // from the memory stage register.
    input  logic      m_valid_i,
    input  logic      m_excp_i,
    input  logic      m_refetch_i,
    input  logic      m_store_i,
    input  logic      m_we_i,
    input  reg_addr_t m_waddr_i,
    input  reg_data_t m_wdata_i,
    input  pc_t       m_pc_i,
    input  logic      m_llbit_we_i,
    input  logic      m_llbit_val_i,

    // toward dispatch.
    output logic      fwd_we_o,
    output reg_addr_t fwd_waddr_o,
    output reg_data_t fwd_wdata_o,

    // toward the data cache.
    output logic      dc_flush_o,
    output logic      dc_store_commit_o,

    // commit record.
    output logic      w_valid_o,
    output logic      w_excp_o,
    output logic      w_we_o,
    output reg_addr_t w_waddr_o,
    output reg_data_t w_wdata_o,
    output pc_t       w_pc_o,
    output logic      w_llbit_we_o,
    output logic      w_llbit_val_o
);

    logic live;

    assign live = m_valid_i & ~m_excp_i;

    assign fwd_we_o    = m_we_i & live;
    assign fwd_waddr_o = m_waddr_i;
    assign fwd_wdata_o = m_wdata_i;

    assign dc_flush_o        = m_valid_i & (m_excp_i | m_refetch_i); // redirect stand-in.
    assign dc_store_commit_o = m_store_i & live;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            w_valid_o     <= 1'b0;
            w_excp_o      <= 1'b0;
            w_we_o        <= 1'b0;
            w_waddr_o     <= '0;
            w_wdata_o     <= '0;
            w_pc_o        <= '0;
            w_llbit_we_o  <= 1'b0;
            w_llbit_val_o <= 1'b0;
        end else if (advance_i) begin
            w_valid_o     <= m_valid_i;
            w_excp_o      <= m_excp_i;
            w_we_o        <= m_we_i;
            w_waddr_o     <= m_waddr_i;
            w_wdata_o     <= m_wdata_i;
            w_pc_o        <= m_pc_i;
            w_llbit_we_o  <= m_llbit_we_i;
            w_llbit_val_o <= m_llbit_val_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        m_excp_i |-> !dc_store_commit_o);

endmodule

//--- source/commit_unit.sv
module commit_unit
    import wb_pkg::*;
#(
    parameter int NUM_LANES = NUM_LANES_DEF
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      advance_i,

    input  logic      [NUM_LANES-1:0] w_valid_i,
    input  logic      [NUM_LANES-1:0] w_excp_i,
    input  logic      [NUM_LANES-1:0] w_we_i,
    input  reg_addr_t [NUM_LANES-1:0] w_waddr_i,
    input  reg_data_t [NUM_LANES-1:0] w_wdata_i,
    input  pc_t       [NUM_LANES-1:0] w_pc_i,
    input  logic      [NUM_LANES-1:0] w_llbit_we_i,
    input  logic      [NUM_LANES-1:0] w_llbit_val_i,

    input  logic      [NUM_LANES-1:0] dc_store_i,
    input  logic      [NUM_LANES-1:0] dc_flush_i,
    input  reg_addr_t                 rf_raddr_i,

    output reg_data_t                 rf_rdata_o,
    output lane_cnt_t                 retire_cnt_o,
    output lane_cnt_t                 store_cnt_o,
    output logic                      dcache_flush_o,
    output logic                      excp_valid_o,
    output pc_t                       excp_pc_o,
    output logic                      llbit_o
);

    reg_data_t            rf [NUM_REGS];

    logic                 adv_q;   // lanes loaded a fresh record last edge.
    logic [NUM_LANES-1:0] st_pend; // store strobes aligned with the record.

    logic [NUM_LANES-1:0] commit_ok;
    logic [NUM_LANES-1:0] excp_hit;
    logic [NUM_LANES-1:0] wr_en;

    lane_cnt_t            retire_n;
    lane_cnt_t            store_n;
    pc_t                  excp_pc_n;
    logic                 llbit_n;

    assign commit_ok = w_valid_i & ~w_excp_i;
    assign excp_hit  = w_valid_i & w_excp_i;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_en[i] = commit_ok[i] & w_we_i[i] & (w_waddr_i[i] != ZERO_REG);
        end
    end

    always_comb begin
        retire_n  = '0;
        store_n   = '0;
        excp_pc_n = '0;
        llbit_n   = llbit_o;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (commit_ok[i]) begin
                retire_n = retire_n + lane_cnt_t'(1);
            end
            if (st_pend[i] && w_valid_i[i]) begin
                store_n = store_n + lane_cnt_t'(1);
            end
            if (commit_ok[i] && w_llbit_we_i[i]) begin
                llbit_n = w_llbit_val_i[i]; // last lane wins.
            end
        end
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (excp_hit[i]) begin
                excp_pc_n = w_pc_i[i];
            end
        end
        if (|excp_hit) begin
            llbit_n = 1'b0;
        end
    end

    // nonblocking order lets the later lane win on a shared address.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (adv_q && wr_en[i]) begin
                rf[w_waddr_i[i]] <= w_wdata_i[i];
            end
        end
    end

    assign rf_rdata_o = (rf_raddr_i == ZERO_REG) ? '0 : rf[rf_raddr_i];

    assign dcache_flush_o = |dc_flush_i;

    always_ff @(posedge clk) begin
        if (advance_i) begin
            st_pend <= dc_store_i;
        end
        if (adv_q && |excp_hit) begin
            excp_pc_o <= excp_pc_n;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            adv_q        <= 1'b0;
            retire_cnt_o <= '0;
            store_cnt_o  <= '0;
            excp_valid_o <= 1'b0;
            llbit_o      <= 1'b0;
        end else begin
            adv_q        <= advance_i;
            retire_cnt_o <= adv_q ? retire_n : '0;
            store_cnt_o  <= adv_q ? store_n : '0;
            excp_valid_o <= adv_q & (|excp_hit);
            if (adv_q) begin
                llbit_o <= llbit_n;
            end
        end
    end

    // squash upstream leaves at most one excepting lane per record.
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(w_valid_i & w_excp_i));

endmodule

//--- source/wb_commit_top.sv
module wb_commit_top
    import wb_pkg::*;
#(
    parameter int NUM_LANES = NUM_LANES_DEF
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_i,
    input  logic                      advance_i,

    input  logic      [NUM_LANES-1:0] valid_i,
    input  logic      [NUM_LANES-1:0] excp_i,
    input  logic      [NUM_LANES-1:0] refetch_i,
    input  logic      [NUM_LANES-1:0] load_i,
    input  logic      [NUM_LANES-1:0] store_i,
    input  logic      [NUM_LANES-1:0] we_i,
    input  reg_addr_t [NUM_LANES-1:0] waddr_i,
    input  reg_data_t [NUM_LANES-1:0] wdata_i,
    input  pc_t       [NUM_LANES-1:0] pc_i,
    input  logic      [NUM_LANES-1:0] llbit_we_i,
    input  logic      [NUM_LANES-1:0] llbit_val_i,

    output logic      [NUM_LANES-1:0] fwd_we_o,
    output reg_addr_t [NUM_LANES-1:0] fwd_waddr_o,
    output reg_data_t [NUM_LANES-1:0] fwd_wdata_o,
    output logic      [NUM_LANES-1:0] dc_flush_o,
    output logic      [NUM_LANES-1:0] dc_store_commit_o,

    input  reg_addr_t                 rf_raddr_i,
    output reg_data_t                 rf_rdata_o,
    output lane_cnt_t                 retire_cnt_o,
    output lane_cnt_t                 store_cnt_o,
    output logic                      dcache_flush_o,
    output logic                      excp_valid_o,
    output pc_t                       excp_pc_o,
    output logic                      llbit_o
);

    logic      [NUM_LANES-1:0] m_valid, m_excp, m_refetch, m_store, m_we;
    logic      [NUM_LANES-1:0] m_llbit_we, m_llbit_val;
    reg_addr_t [NUM_LANES-1:0] m_waddr;
    reg_data_t [NUM_LANES-1:0] m_wdata;
    pc_t       [NUM_LANES-1:0] m_pc;

    logic      [NUM_LANES-1:0] w_valid, w_excp, w_we, w_llbit_we, w_llbit_val;
    reg_addr_t [NUM_LANES-1:0] w_waddr;
    reg_data_t [NUM_LANES-1:0] w_wdata;
    pc_t       [NUM_LANES-1:0] w_pc;

    mem_stage_reg #(
        .NUM_LANES (NUM_LANES)
    ) u_mem_stage_reg (
        .clk, .rst, .flush_i, .advance_i,
        .valid_i, .excp_i, .refetch_i, .load_i, .store_i, .we_i,
        .waddr_i, .wdata_i, .pc_i, .llbit_we_i, .llbit_val_i,
        .m_valid_o     (m_valid),
        .m_excp_o      (m_excp),
        .m_refetch_o   (m_refetch),
        .m_load_o      (),              // loads need no writeback action.
        .m_store_o     (m_store),
        .m_we_o        (m_we),
        .m_waddr_o     (m_waddr),
        .m_wdata_o     (m_wdata),
        .m_pc_o        (m_pc),
        .m_llbit_we_o  (m_llbit_we),
        .m_llbit_val_o (m_llbit_val)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        wb_lane u_wb_lane (
            .clk, .rst, .flush_i, .advance_i,
            .m_valid_i         (m_valid[g]),
            .m_excp_i          (m_excp[g]),
            .m_refetch_i       (m_refetch[g]),
            .m_store_i         (m_store[g]),
            .m_we_i            (m_we[g]),
            .m_waddr_i         (m_waddr[g]),
            .m_wdata_i         (m_wdata[g]),
            .m_pc_i            (m_pc[g]),
            .m_llbit_we_i      (m_llbit_we[g]),
            .m_llbit_val_i     (m_llbit_val[g]),
            .fwd_we_o          (fwd_we_o[g]),
            .fwd_waddr_o       (fwd_waddr_o[g]),
            .fwd_wdata_o       (fwd_wdata_o[g]),
            .dc_flush_o        (dc_flush_o[g]),
            .dc_store_commit_o (dc_store_commit_o[g]),
            .w_valid_o         (w_valid[g]),
            .w_excp_o          (w_excp[g]),
            .w_we_o            (w_we[g]),
            .w_waddr_o         (w_waddr[g]),
            .w_wdata_o         (w_wdata[g]),
            .w_pc_o            (w_pc[g]),
            .w_llbit_we_o      (w_llbit_we[g]),
            .w_llbit_val_o     (w_llbit_val[g])
        );
    end

    commit_unit #(
        .NUM_LANES (NUM_LANES)
    ) u_commit_unit (
        .clk, .rst, .advance_i,
        .w_valid_i     (w_valid),
        .w_excp_i      (w_excp),
        .w_we_i        (w_we),
        .w_waddr_i     (w_waddr),
        .w_wdata_i     (w_wdata),
        .w_pc_i        (w_pc),
        .w_llbit_we_i  (w_llbit_we),
        .w_llbit_val_i (w_llbit_val),
        .dc_store_i    (dc_store_commit_o),
        .dc_flush_i    (dc_flush_o),
        .rf_raddr_i,
        .rf_rdata_o, .retire_cnt_o, .store_cnt_o, .dcache_flush_o,
        .excp_valid_o, .excp_pc_o, .llbit_o
    );

endmodule

//--- tb/tb_wb_commit.sv
module tb_wb_commit
    import wb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int  NL         = 2;
    localparam int  MAX_ROWS   = 96;
    localparam int  RST_CYCLES = 4;
    localparam int  CLK_PERIOD = 8;
    localparam pc_t PC_BASE    = 32'h1c00_0000;

    logic               clk = 1'b0;
    logic               rst, flush, advance;
    logic      [NL-1:0] valid, excp, refetch, load, store, we, llbit_we, llbit_val;
    reg_addr_t [NL-1:0] waddr;
    reg_data_t [NL-1:0] wdata;
    pc_t       [NL-1:0] pc;
    reg_addr_t          rf_raddr;

    logic      [NL-1:0] fwd_we, dc_flush, dc_store_commit;
    reg_addr_t [NL-1:0] fwd_waddr;
    reg_data_t [NL-1:0] fwd_wdata;
    reg_data_t          rf_rdata;
    lane_cnt_t          retire_cnt, store_cnt;
    logic               dcache_flush, excp_valid, llbit;
    pc_t                excp_pc;

    // stimulus table, one row per cycle.
    logic               t_flush [MAX_ROWS];
    logic               t_adv   [MAX_ROWS];
    logic      [NL-1:0] t_valid [MAX_ROWS];
    logic      [NL-1:0] t_excp  [MAX_ROWS];
    logic      [NL-1:0] t_ref   [MAX_ROWS];
    logic      [NL-1:0] t_store [MAX_ROWS];
    logic      [NL-1:0] t_we    [MAX_ROWS];
    logic      [NL-1:0] t_llwe  [MAX_ROWS];
    logic      [NL-1:0] t_llval [MAX_ROWS];
    reg_addr_t [NL-1:0] t_waddr [MAX_ROWS];
    reg_data_t [NL-1:0] t_wdata [MAX_ROWS];
    int                 n_rows = 0;
    logic               table_done = 1'b0;
    int                 seed = 32'h3d26_5b9c;

    // reference model, memory stage (m) and writeback record (w).
    logic      [NL-1:0] mv, mexcp, mref, mst, mwe, mllwe, mllval;
    reg_addr_t [NL-1:0] mwa;
    reg_data_t [NL-1:0] mwd;
    pc_t       [NL-1:0] mpc;
    logic      [NL-1:0] wv, wexcp, wst, wwe, wllwe, wllval;
    reg_addr_t [NL-1:0] wwa;
    reg_data_t [NL-1:0] wwd;
    pc_t       [NL-1:0] wpc;
    logic               adv_q, exp_excp, exp_ll;
    lane_cnt_t          exp_retire, exp_store;
    pc_t                exp_pc;
    reg_data_t          regs  [NUM_REGS];
    logic               known [NUM_REGS];

    wb_commit_top #(
        .NUM_LANES (NL)
    ) uut (
        .clk, .rst,
        .flush_i           (flush),
        .advance_i         (advance),
        .valid_i           (valid),
        .excp_i            (excp),
        .refetch_i         (refetch),
        .load_i            (load),
        .store_i           (store),
        .we_i              (we),
        .waddr_i           (waddr),
        .wdata_i           (wdata),
        .pc_i              (pc),
        .llbit_we_i        (llbit_we),
        .llbit_val_i       (llbit_val),
        .fwd_we_o          (fwd_we),
        .fwd_waddr_o       (fwd_waddr),
        .fwd_wdata_o       (fwd_wdata),
        .dc_flush_o        (dc_flush),
        .dc_store_commit_o (dc_store_commit),
        .rf_raddr_i        (rf_raddr),
        .rf_rdata_o        (rf_rdata),
        .retire_cnt_o      (retire_cnt),
        .store_cnt_o       (store_cnt),
        .dcache_flush_o    (dcache_flush),
        .excp_valid_o      (excp_valid),
        .excp_pc_o         (excp_pc),
        .llbit_o           (llbit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("Error: %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_cnt(input lane_cnt_t got, input lane_cnt_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    function automatic pc_t row_pc(input int r, input int lane);
        return PC_BASE + pc_t'(r * 8 + lane * 4);
    endfunction

    task automatic add_row(input logic fl, input logic adv, input logic [NL-1:0] v,
                           input logic [NL-1:0] ex, input logic [NL-1:0] rf,
                           input logic [NL-1:0] st, input logic [NL-1:0] wr,
                           input reg_addr_t a0, input reg_addr_t a1,
                           input logic [NL-1:0] llw, input logic [NL-1:0] llv);
        t_flush[n_rows] = fl;
        t_adv[n_rows]   = adv;
        t_valid[n_rows] = v;
        t_excp[n_rows]  = ex;
        t_ref[n_rows]   = rf;
        t_store[n_rows] = st;
        t_we[n_rows]    = wr;
        t_llwe[n_rows]  = llw;
        t_llval[n_rows] = llv;
        t_waddr[n_rows] = {a1, a0};
        for (int i = 0; i < NL; i++) begin
            t_wdata[n_rows][i] = $random(seed);
        end
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        // r0 is among the targets and has to stay zero.
        for (int k = 0; k < 16; k++) begin
            add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11,
                    reg_addr_t'(2 * k), reg_addr_t'(2 * k + 1), 2'b00, 2'b00);
        end
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 5, 5, 2'b00, 2'b00); // lane 1 wins.
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b01, 6, 7, 2'b01, 2'b01);
        add_row(0, 1, 2'b11, 2'b01, 2'b00, 2'b00, 2'b11, 8, 9, 2'b00, 2'b00); // lane 0 excepts.
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 10, 11, 2'b11, 2'b10);
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b00, 0, 0, 2'b11, 2'b01);
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b11, 2'b00, 0, 0, 2'b00, 2'b00); // two stores.
        add_row(0, 1, 2'b11, 2'b10, 2'b00, 2'b11, 2'b01, 12, 13, 2'b00, 2'b00);
        add_row(0, 1, 2'b11, 2'b00, 2'b01, 2'b00, 2'b11, 14, 15, 2'b00, 2'b00); // refetch.
        add_row(0, 1, 2'b10, 2'b01, 2'b00, 2'b00, 2'b11, 16, 17, 2'b00, 2'b00);
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 18, 19, 2'b00, 2'b00);
        // stalled rows are never captured.
        add_row(0, 0, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 20, 21, 2'b00, 2'b00);
        add_row(0, 0, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 20, 21, 2'b00, 2'b00);
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 22, 23, 2'b00, 2'b00);
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 24, 25, 2'b00, 2'b00);
        add_row(1, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 26, 27, 2'b00, 2'b00); // drops r24/r25.
        add_row(0, 1, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 28, 29, 2'b00, 2'b00);
        add_row(1, 0, 2'b11, 2'b00, 2'b00, 2'b00, 2'b11, 30, 31, 2'b00, 2'b00);
        for (int k = 0; k < 12; k++) begin
            rnd = $random(seed);
            add_row(rnd[3:0] == 4'd0, rnd[5:4] != 2'd0, rnd[7:6], rnd[9:8] & rnd[11:10],
                    rnd[13:12] & rnd[15:14], rnd[17:16], rnd[19:18],
                    rnd[24:20], rnd[29:25], rnd[31:30], rnd[1:0]);
        end
        // idle rows drain the pipeline and sweep every register.
        for (int k = 0; k < 34; k++) begin
            add_row(0, 1, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
        end
    endtask

    task automatic drive_row(input int r);
        flush     = t_flush[r];
        advance   = t_adv[r];
        valid     = t_valid[r];
        excp      = t_excp[r];
        refetch   = t_ref[r];
        load      = t_llwe[r]; // load-linked ops are loads.
        store     = t_store[r];
        we        = t_we[r];
        waddr     = t_waddr[r];
        wdata     = t_wdata[r];
        llbit_we  = t_llwe[r];
        llbit_val = t_llval[r];
        rf_raddr  = reg_addr_t'(r);
        for (int i = 0; i < NL; i++) begin
            pc[i] = row_pc(r, i);
        end
    endtask

    // state after the coming edge, commit first, then w, then m.
    task automatic step_model(input int r);
        logic      kill;
        logic      hit;
        lane_cnt_t ret;
        lane_cnt_t sto;
        kill = 1'b0;
        hit  = 1'b0;
        ret  = '0;
        sto  = '0;
        if (adv_q) begin
            for (int i = 0; i < NL; i++) begin
                if (wv[i] && wexcp[i]) begin
                    if (!hit) exp_pc = wpc[i];
                    hit = 1'b1;
                end else if (wv[i]) begin
                    ret = ret + 1'b1;
                    if (wst[i]) sto = sto + 1'b1;
                    if (wwe[i] && wwa[i] != '0) begin
                        regs[wwa[i]]  = wwd[i];
                        known[wwa[i]] = 1'b1;
                    end
                    if (wllwe[i]) exp_ll = wllval[i];
                end
            end
            if (hit) exp_ll = 1'b0;
        end
        exp_excp   = hit;
        exp_retire = ret;
        exp_store  = sto;
        if (t_flush[r]) begin
            wv = '0;
        end else if (t_adv[r]) begin
            wv     = mv;
            wexcp  = mexcp;
            wst    = mst & mv & ~mexcp;
            wwe    = mwe;
            wwa    = mwa;
            wwd    = mwd;
            wpc    = mpc;
            wllwe  = mllwe;
            wllval = mllval;
        end
        if (t_flush[r]) begin
            mv = '0;
        end else if (t_adv[r]) begin
            for (int i = 0; i < NL; i++) begin
                mv[i]  = t_valid[r][i] & ~kill;
                mpc[i] = row_pc(r, i);
                if (mv[i] && (t_excp[r][i] || t_ref[r][i])) kill = 1'b1;
            end
            mexcp  = t_excp[r];
            mref   = t_ref[r];
            mst    = t_store[r];
            mwe    = t_we[r];
            mwa    = t_waddr[r];
            mwd    = t_wdata[r];
            mllwe  = t_llwe[r];
            mllval = t_llval[r];
        end
        adv_q = t_adv[r];
    endtask

    task automatic check_outputs();
        for (int i = 0; i < NL; i++) begin
            check_flag(fwd_we[i], mv[i] & mwe[i] & ~mexcp[i], $sformatf("lane %0d fwd_we", i));
            if (mv[i] && mwe[i] && !mexcp[i]) begin
                check_addr(fwd_waddr[i], mwa[i], $sformatf("lane %0d fwd_waddr", i));
                check_data(fwd_wdata[i], mwd[i], $sformatf("lane %0d fwd_wdata", i));
            end
            check_flag(dc_store_commit[i], mst[i] & mv[i] & ~mexcp[i],
                       $sformatf("lane %0d dc_store_commit", i));
            check_flag(dc_flush[i], mv[i] & (mexcp[i] | mref[i]),
                       $sformatf("lane %0d dc_flush", i));
        end
        check_flag(dcache_flush, |(mv & (mexcp | mref)), "dcache_flush");
        check_cnt(retire_cnt, exp_retire, "retire_cnt");
        check_cnt(store_cnt, exp_store, "store_cnt");
        check_flag(excp_valid, exp_excp, "excp_valid");
        if (exp_excp) check_pc(excp_pc, exp_pc, "excp_pc");
        check_flag(llbit, exp_ll, "llbit");
        if (known[rf_raddr]) begin
            check_data(rf_rdata, regs[rf_raddr], $sformatf("read of r%0d", rf_raddr));
        end
    endtask

    initial begin
        wait (table_done);
        #((n_rows + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", n_rows + 20);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        advance   = 1'b0;
        valid     = '0;
        excp      = '0;
        refetch   = '0;
        load      = '0;
        store     = '0;
        we        = '0;
        waddr     = '0;
        wdata     = '0;
        pc        = '0;
        llbit_we  = '0;
        llbit_val = '0;
        rf_raddr  = '0;
        mv        = '0;
        wv        = '0;
        adv_q     = 1'b0;
        exp_excp  = 1'b0;
        exp_ll    = 1'b0;
        exp_retire = '0;
        exp_store  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i]  = '0;
            known[i] = (i == 0); // r0 reads zero from the start.
        end
        build_table();
        table_done = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            check_outputs();
            drive_row(r);
            step_model(r);
            @(negedge clk);
        end
        check_outputs();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- wb_commit_top.f
source/wb_pkg.sv
source/mem_stage_reg.sv
source/wb_lane.sv
source/commit_unit.sv
source/wb_commit_top.sv
tb/tb_wb_commit.sv

//--- Bender.yml
package:
  name: wb_commit

sources:
  - source/wb_pkg.sv
  - source/mem_stage_reg.sv
  - source/wb_lane.sv
  - source/commit_unit.sv
  - source/wb_commit_top.sv

  - target: test
    files:
      - tb/tb_wb_commit.sv
